/* rtl/periph_pkg.sv */
// Controller-port peripheral definitions
// Shared key codes, debounced state, bus request and register map

package periph_pkg;

    // Keypad code reported to the CPU, 15 means no key held
    typedef enum logic [3:0] {
        KEY_0    = 4'd0,
        KEY_1    = 4'd1,
        KEY_2    = 4'd2,
        KEY_3    = 4'd3,
        KEY_4    = 4'd4,
        KEY_5    = 4'd5,
        KEY_6    = 4'd6,
        KEY_7    = 4'd7,
        KEY_8    = 4'd8,
        KEY_9    = 4'd9,
        KEY_STAR = 4'd10,
        KEY_HASH = 4'd11,
        KEY_NONE = 4'd15
    } key_code_e;

    // Debounced levels, all active high
    typedef struct packed {
        logic [11:0] keys;     // Bit i is the key with code i
        logic [1:0]  fire;     // Top and bottom fire buttons
        logic [2:0]  console;  // Start, pause, reset
    } ctrl_state_t;

    // One-cycle press pulse with the new code
    typedef struct packed {
        logic      press;
        key_code_e code;
    } key_event_t;

    // Register addresses
    typedef enum logic [1:0] {
        REG_KBCODE  = 2'd0,
        REG_STATUS  = 2'd1,
        REG_IRQ_EN  = 2'd2,
        REG_IRQ_CLR = 2'd3
    } reg_addr_e;

    // CPU request, rd and wr are single-cycle strobes
    typedef struct packed {
        logic       rd;
        logic       wr;
        reg_addr_e  addr;
        logic [7:0] wdata;
    } bus_req_t;

    // STATUS register bit positions, bit 7 reads zero
    localparam int STAT_HELD    = 0;
    localparam int STAT_FIRE_LO = 1;
    localparam int STAT_FIRE_HI = 2;
    localparam int STAT_CONS_LO = 3;
    localparam int STAT_CONS_HI = 5;
    localparam int STAT_PEND    = 6;

endpackage

/* rtl/debounce.sv */
// Switch debouncer
// Synchronizes one raw line and passes it on only after it has
// held steady for half the counter range

`timescale 1ns/1ps

module debounce #(
    parameter int DB_BITS = 11
) (
    input  logic clk,
    input  logic n_reset,
    input  logic raw,
    output logic level
);

    logic               sync_a;
    logic               sync_b;
    logic [DB_BITS-1:0] count;
    logic [DB_BITS-1:0] count_next;
    logic               changed;
    logic               stable;

    // Flops disagree while the input is moving
    assign changed = sync_a ^ sync_b;
    // Top bit set means the line has been quiet long enough
    assign stable  = count[DB_BITS-1];

    // Counter clears on any change and saturates at the top bit
    always_comb
    begin
        if (changed)
            count_next = '0;
        else if (!stable)
            count_next = count + 1'b1;
        else
            count_next = count;
    end

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            sync_a <= 1'b0;
            sync_b <= 1'b0;
            count  <= '0;
            level  <= 1'b0;
        end
        else
        begin
            // Two-flop synchronizer on the asynchronous switch
            sync_a <= raw;
            sync_b <= sync_a;
            count  <= count_next;
            // Output follows only once the counter has saturated
            if (stable)
                level <= sync_b;
        end
    end

endmodule

/* rtl/keypad_encoder.sv */
// Keypad encoder
// Priority-encodes the debounced keys, lowest index wins, and
// emits one press event each time the code moves to a real key

`timescale 1ns/1ps

module keypad_encoder
    import periph_pkg::*;
(
    input  logic       clk,
    input  logic       n_reset,
    input  logic [11:0] keys,
    output key_event_t event_out
);

    key_code_e cur_code;
    key_code_e last_code;
    logic      press;

    // Scan from the top so the lowest held index is left standing
    always_comb
    begin
        cur_code = KEY_NONE;
        for (int i = 11; i >= 0; i--)
        begin
            if (keys[i])
                cur_code = key_code_e'(4'(i));
        end
    end

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            last_code <= KEY_NONE;
            press     <= 1'b0;
        end
        else
        begin
            last_code <= cur_code;
            // New key, or a slide from one key to another
            // Releasing everything gives no event
            press <= (cur_code != last_code) && (cur_code != KEY_NONE);
        end
    end

    // last_code is loaded on the same edge as press, so the pair
    // lines up as the event payload
    assign event_out.press = press;
    assign event_out.code  = last_code;

endmodule

/* rtl/periph_regs.sv */
// Controller-port register block
// Holds the last key code, interrupt enable and pending flag, and
// answers CPU reads of these and of the live button status

`timescale 1ns/1ps

module periph_regs
    import periph_pkg::*;
(
    input  logic        clk,
    input  logic        n_reset,
    input  bus_req_t    bus,
    input  ctrl_state_t state,
    input  key_event_t  key_event,
    output logic [7:0]  rdata,
    output logic        irq
);

    key_code_e  kbcode;
    logic       irq_en;
    logic       pending;
    logic [7:0] status;
    logic [7:0] rd_mux;
    logic       wr_en;
    logic       wr_clr;

    // Decoded write strobes
    assign wr_en  = bus.wr && (bus.addr == REG_IRQ_EN);
    assign wr_clr = bus.wr && (bus.addr == REG_IRQ_CLR) && bus.wdata[0];

    // Live status word
    always_comb
    begin
        status = 8'h00;
        status[STAT_HELD] = |state.keys;
        status[STAT_FIRE_HI:STAT_FIRE_LO] = state.fire;
        status[STAT_CONS_HI:STAT_CONS_LO] = state.console;
        status[STAT_PEND] = pending;
    end

    // Read select
    always_comb
    begin
        case (bus.addr)
            REG_KBCODE:
                rd_mux = {4'h0, kbcode};
            REG_STATUS:
                rd_mux = status;
            REG_IRQ_EN:
                rd_mux = {7'h00, irq_en};
            default:
                rd_mux = 8'h00;
        endcase
    end

    // Key code and pending flag
    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            kbcode  <= KEY_NONE;
            pending <= 1'b0;
        end
        else
        begin
            if (key_event.press)
            begin
                // A press beats a clear on the same edge
                kbcode  <= key_event.code;
                pending <= 1'b1;
            end
            else if (wr_clr)
            begin
                pending <= 1'b0;
            end
        end
    end

    // Enable, read data and interrupt line
    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            irq_en <= 1'b0;
            rdata  <= 8'h00;
            irq    <= 1'b0;
        end
        else
        begin
            if (wr_en)
                irq_en <= bus.wdata[0];
            // Read data holds until the next read strobe
            if (bus.rd)
                rdata <= rd_mux;
            irq <= pending & irq_en;
        end
    end

endmodule

/* rtl/periph_top.sv */
// Controller-port peripheral top level
// Debounces all seventeen switch lines, encodes the keypad and
// presents the register block to the CPU

`timescale 1ns/1ps

module periph_top
    import periph_pkg::*;
#(
    parameter int DB_BITS = 11
) (
    input  logic        clk,
    input  logic        n_reset,
    input  logic [11:0] raw_keys,
    input  logic [1:0]  raw_fire,
    input  logic [2:0]  raw_console,
    input  bus_req_t    bus,
    output logic [7:0]  rdata,
    output logic        irq
);

    localparam int NUM_LINES = 17;

    logic [NUM_LINES-1:0] raw_lines;
    logic [NUM_LINES-1:0] db_lines;
    ctrl_state_t          state;
    key_event_t           key_event;

    // Same bit order as ctrl_state_t, keys at the top
    assign raw_lines = {raw_keys, raw_fire, raw_console};
    assign state     = db_lines;

    // One debouncer per switch line
    for (genvar i = 0; i < NUM_LINES; i++)
    begin : g_db
        debounce #(
            .DB_BITS (DB_BITS)
        ) debounce_i (
            .clk     (clk),
            .n_reset (n_reset),
            .raw     (raw_lines[i]),
            .level   (db_lines[i])
        );
    end

    keypad_encoder keypad_encoder_i (
        .clk       (clk),
        .n_reset   (n_reset),
        .keys      (state.keys),
        .event_out (key_event)
    );

    periph_regs periph_regs_i (
        .clk       (clk),
        .n_reset   (n_reset),
        .bus       (bus),
        .state     (state),
        .key_event (key_event),
        .rdata     (rdata),
        .irq       (irq)
    );

endmodule

/* tb/tb_periph.sv */
// Testbench for the controller-port peripheral
// Random switch and bus stimulus checked against a behavioral model

`timescale 1ns/1ps

module tb_periph
    import periph_pkg::*;
();

    localparam int DB_BITS = 4;
    // Debounce settles in 11 cycles, the press reaches irq 3 cycles later
    localparam int HOLD    = 16;
    localparam int LIMIT   = 64;

    logic        clk;
    logic        n_reset;
    logic [11:0] raw_keys;
    logic [1:0]  raw_fire;
    logic [2:0]  raw_console;
    bus_req_t    bus;
    logic [7:0]  rdata;
    logic        irq;

    // Model state
    logic [31:0] rng;
    logic [11:0] m_keys;
    logic [1:0]  m_fire;
    logic [2:0]  m_console;
    logic [3:0]  m_code;
    logic [3:0]  m_kbcode;
    logic        m_en;
    logic        m_pend;

    periph_top #(
        .DB_BITS (DB_BITS)
    ) periph_top_i (
        .clk         (clk),
        .n_reset     (n_reset),
        .raw_keys    (raw_keys),
        .raw_fire    (raw_fire),
        .raw_console (raw_console),
        .bus         (bus),
        .rdata       (rdata),
        .irq         (irq)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    // LCG step
    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    // Lowest held key index, 15 when nothing is held
    function automatic logic [3:0] lowest_key(input logic [11:0] k);
        logic [3:0] code;
        logic       found;
        code  = 4'hf;
        found = 1'b0;
        for (int i = 0; i < 12; i++)
        begin
            if (k[i] && !found)
            begin
                code  = 4'(i);
                found = 1'b1;
            end
        end
        return code;
    endfunction

    function automatic logic [7:0] expect_read(input reg_addr_e addr);
        logic [7:0] s;
        s = (8'(m_keys != 12'h000) << STAT_HELD)
            | (8'(m_fire) << STAT_FIRE_LO)
            | (8'(m_console) << STAT_CONS_LO)
            | (8'(m_pend) << STAT_PEND);
        case (addr)
            REG_KBCODE: return {4'h0, m_kbcode};
            REG_STATUS: return s;
            REG_IRQ_EN: return {7'h00, m_en};
            default:    return 8'h00;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            $display("error %s expected %0h actual %0h", name, exp, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // Drive new switch levels, hold them, then advance the model
    task automatic apply_levels(input logic [11:0] k, input logic [1:0] f, input logic [2:0] c);
        logic [3:0] code;
        @(posedge clk);
        #1;
        raw_keys    = k;
        raw_fire    = f;
        raw_console = c;
        repeat (HOLD) @(posedge clk);
        #1;
        m_keys    = k;
        m_fire    = f;
        m_console = c;
        code      = lowest_key(k);
        // Only a move to a real key counts as a press
        if (code != m_code && code != 4'hf)
        begin
            m_kbcode = code;
            m_pend   = 1'b1;
        end
        m_code = code;
    endtask

    // Short glitch on fire and console lines, then back to the old level
    task automatic pulse_buttons(input logic [4:0] mask, input int len);
        logic [4:0] flip;
        // Empty mask glitches every line
        flip = (mask == 5'h00) ? 5'h1f : mask;
        @(posedge clk);
        #1;
        {raw_fire, raw_console} = {m_fire, m_console} ^ flip;
        repeat (len) @(posedge clk);
        #1;
        {raw_fire, raw_console} = {m_fire, m_console};
        repeat (HOLD) @(posedge clk);
        #1;
    endtask

    task automatic read_check(input string name, input reg_addr_e addr);
        @(posedge clk);
        #1;
        bus.rd   = 1'b1;
        bus.addr = addr;
        @(posedge clk);
        #1;
        bus.rd = 1'b0;
        check(name, expect_read(addr), rdata);
    endtask

    task automatic write_reg(input reg_addr_e addr, input logic [7:0] data);
        @(posedge clk);
        #1;
        bus.wr    = 1'b1;
        bus.addr  = addr;
        bus.wdata = data;
        @(posedge clk);
        #1;
        bus.wr = 1'b0;
        if (addr == REG_IRQ_EN)
            m_en = data[0];
        if (addr == REG_IRQ_CLR && data[0])
            m_pend = 1'b0;
    endtask

    task automatic wait_irq(input logic exp);
        int n;
        n = 0;
        while (irq !== exp && n < LIMIT)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        if (irq !== exp)
        begin
            $display("timeout waiting for irq to become %0d", exp);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // irq lags pending and enable by one edge
    task automatic check_irq(input string name);
        @(posedge clk);
        #1;
        check(name, m_pend & m_en, irq);
    endtask

    // Random non-empty key set
    function automatic logic [11:0] some_keys();
        logic [31:0] r;
        r = next_rand();
        if (r[27:16] == 12'h000)
            return 12'h001 << (r[3:0] % 12);
        return r[27:16];
    endfunction

    initial
    begin
        logic [31:0] r;
        rng         = 32'h07113c9e;
        n_reset     = 1'b0;
        raw_keys    = '0;
        raw_fire    = '0;
        raw_console = '0;
        bus         = '0;
        {m_keys, m_fire, m_console} = '0;
        m_code   = 4'hf;
        m_kbcode = 4'hf;
        m_en     = 1'b0;
        m_pend   = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        n_reset = 1'b1;

        // Reset values
        read_check("reset kbcode", REG_KBCODE);
        read_check("reset status", REG_STATUS);
        read_check("reset irq_en", REG_IRQ_EN);
        check("reset irq", 1'b0, irq);

        // Debounced buttons and rejected glitches
        for (int i = 0; i < 12; i++)
        begin
            r = next_rand();
            apply_levels(m_keys, r[17:16], r[22:20]);
            read_check("button status", REG_STATUS);
            r = next_rand();
            pulse_buttons(r[20:16], 1 + (r[3:0] % 4));
            read_check("glitch status", REG_STATUS);
        end

        // Key priority, release keeps the code
        for (int i = 0; i < 10; i++)
        begin
            apply_levels(some_keys(), m_fire, m_console);
            read_check("key code", REG_KBCODE);
            read_check("key status", REG_STATUS);
        end
        apply_levels(12'h000, m_fire, m_console);
        read_check("release code", REG_KBCODE);
        read_check("release status", REG_STATUS);

        // Interrupt raise and clear
        write_reg(REG_IRQ_CLR, 8'h01);
        write_reg(REG_IRQ_EN, 8'h01);
        apply_levels(some_keys(), m_fire, m_console);
        wait_irq(1'b1);
        read_check("irq status", REG_STATUS);
        write_reg(REG_IRQ_CLR, 8'h01);
        wait_irq(1'b0);
        read_check("clear status", REG_STATUS);

        // Masked interrupt shows only in STATUS
        write_reg(REG_IRQ_EN, 8'h00);
        apply_levels(12'h000, m_fire, m_console);
        apply_levels(some_keys(), m_fire, m_console);
        read_check("masked status", REG_STATUS);
        check("masked irq", 1'b0, irq);
        write_reg(REG_IRQ_EN, 8'h01);
        wait_irq(1'b1);

        // Random mix of switches and bus traffic
        for (int i = 0; i < 200; i++)
        begin
            r = next_rand();
            case (r[26:24] % 6)
                0: apply_levels(some_keys(), m_fire, m_console);
                1: apply_levels(12'h000, m_fire, m_console);
                2: apply_levels(m_keys, r[17:16], r[22:20]);
                3: read_check("mix read", reg_addr_e'(r[17:16]));
                4: write_reg(REG_IRQ_EN, {7'h00, r[16]});
                default: write_reg(REG_IRQ_CLR, r[23:16]);
            endcase
            check_irq("mix irq");
        end

        $display("sim passed");
        $finish;
    end

endmodule

/* build.f */
rtl/periph_pkg.sv
rtl/debounce.sv
rtl/keypad_encoder.sv
rtl/periph_regs.sv
rtl/periph_top.sv
tb/tb_periph.sv
